// ==== src/muldiv_pkg.sv ====
/*
 * shared encodings for the M-extension execution subsystem
 * data width is a module parameter (XLEN) and does not live here
 */

package muldiv_pkg;

    // register file address, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // top bit marks the divide class, low two bits pick the variant
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    // multiplier variant, same order as the low bits above
    typedef enum logic [1:0] {
        MUL_LO  = 2'b00,
        MUL_HSS = 2'b01,
        MUL_HSU = 2'b10,
        MUL_HUU = 2'b11
    } mul_op_e;

    // divider variant, same order as the low bits above
    typedef enum logic [1:0] {
        DIV_S = 2'b00,
        DIV_U = 2'b01,
        REM_S = 2'b10,
        REM_U = 2'b11
    } div_op_e;

endpackage

// ==== src/exu_muldiv_ctrl.sv ====
/*
 * request decode, start pulses, pipeline hold and write-back merge
 * dispatch must keep the request stable while the hold flag is high
 * only one unit is in flight at a time
 */

`timescale 1ns/1ps

module exu_muldiv_ctrl import muldiv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // dispatch side
    input  logic                  req_muldiv_i,
    input  muldiv_op_e            muldiv_op_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    input  logic [XLEN-1:0]       reg1_rdata_i,
    input  logic [XLEN-1:0]       reg2_rdata_i,

    // multiplier status
    input  logic                  mul_ready_i,
    input  logic                  mul_busy_i,
    input  logic [XLEN-1:0]       mul_result_i,
    input  logic [REG_ADDR_W-1:0] mul_reg_waddr_i,

    // divider status
    input  logic                  div_ready_i,
    input  logic                  div_busy_i,
    input  logic [XLEN-1:0]       div_result_i,
    input  logic [REG_ADDR_W-1:0] div_reg_waddr_i,

    // multiplier command
    output logic                  mul_start_o,
    output mul_op_e               mul_op_o,
    output logic [XLEN-1:0]       mul_multiplicand_o,
    output logic [XLEN-1:0]       mul_multiplier_o,
    output logic [REG_ADDR_W-1:0] mul_reg_waddr_o,

    // divider command
    output logic                  div_start_o,
    output div_op_e               div_op_o,
    output logic [XLEN-1:0]       div_dividend_o,
    output logic [XLEN-1:0]       div_divisor_o,
    output logic [REG_ADDR_W-1:0] div_reg_waddr_o,

    // pipeline hold and register write-back
    output logic                  muldiv_hold_flag_o,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o,
    output logic [XLEN-1:0]       reg_wdata_o
);

    logic is_mul_req;
    logic is_div_req;
    logic started_q;

    // class split on the top opcode bit
    assign is_div_req = req_muldiv_i && muldiv_op_i[2];
    assign is_mul_req = req_muldiv_i && !muldiv_op_i[2];

    assign mul_op_o           = mul_op_e'(muldiv_op_i[1:0]);
    assign mul_multiplicand_o = reg1_rdata_i;
    assign mul_multiplier_o   = reg2_rdata_i;
    assign mul_reg_waddr_o    = reg_waddr_i;

    assign div_op_o           = div_op_e'(muldiv_op_i[1:0]);
    assign div_dividend_o     = reg1_rdata_i;
    assign div_divisor_o      = reg2_rdata_i;
    assign div_reg_waddr_o    = reg_waddr_i;

    // one start per request, never while the unit is occupied
    assign mul_start_o = is_mul_req && !mul_busy_i && !mul_ready_i && !started_q;
    assign div_start_o = is_div_req && !div_busy_i && !div_ready_i && !started_q;

    // request already issued, cleared when its result is written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            started_q <= 1'b0;
        end else if (mul_ready_i || div_ready_i) begin
            started_q <= 1'b0;
        end else if (mul_start_o || div_start_o) begin
            started_q <= 1'b1;
        end
    end

    // drops in the write-back cycle so dispatch can move on
    assign muldiv_hold_flag_o = (is_mul_req && !mul_ready_i) ||
                                (is_div_req && !div_ready_i) ||
                                mul_busy_i || div_busy_i;

    // ready pulses never overlap
    always_comb begin
        reg_we_o    = mul_ready_i || div_ready_i;
        reg_waddr_o = '0;
        reg_wdata_o = '0;
        if (mul_ready_i) begin
            reg_waddr_o = mul_reg_waddr_i;
            reg_wdata_o = mul_result_i;
        end else if (div_ready_i) begin
            reg_waddr_o = div_reg_waddr_i;
            reg_wdata_o = div_result_i;
        end
    end

endmodule

// ==== src/exu_mul.sv ====
/*
 * iterative shift-add multiplier, one partial product per cycle
 * ready pulses XLEN cycles after start, XLEN must be at least 2
 * start is ignored while busy
 */

`timescale 1ns/1ps

module exu_mul import muldiv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  mul_op_e               op_i,
    input  logic [XLEN-1:0]       multiplicand_i,
    input  logic [XLEN-1:0]       multiplier_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    output logic                  busy_o,
    output logic                  ready_o,
    output logic [XLEN-1:0]       result_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o
);

    localparam int CNT_W = $clog2(XLEN);

    logic [2*XLEN-1:0]     a_ext;
    logic                  b_signed;
    logic [2*XLEN-1:0]     a_q;
    logic [XLEN-1:0]       b_q;
    logic [2*XLEN-1:0]     acc_q;
    logic                  b_signed_q;
    mul_op_e               op_q;
    logic [REG_ADDR_W-1:0] waddr_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  busy_q;
    logic                  ready_q;

    // multiplicand is signed for both MULH and MULHSU
    always_comb begin
        b_signed = (op_i == MUL_HSS);
        if (op_i == MUL_HSS || op_i == MUL_HSU) begin
            a_ext = {{XLEN{multiplicand_i[XLEN-1]}}, multiplicand_i};
        end else begin
            a_ext = {{XLEN{1'b0}}, multiplicand_i};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(1);
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(XLEN-1)) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                end
            end
        end
    end

    // datapath, first partial product is taken in the start cycle
    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            acc_q      <= multiplier_i[0] ? a_ext : '0;
            a_q        <= a_ext << 1;
            b_q        <= multiplier_i >> 1;
            b_signed_q <= b_signed;
            op_q       <= op_i;
            waddr_q    <= reg_waddr_i;
        end else if (busy_q) begin
            // top bit of a signed multiplier weighs -2^(XLEN-1)
            if (b_q[0]) begin
                if (b_signed_q && cnt_q == CNT_W'(XLEN-1)) begin
                    acc_q <= acc_q - a_q;
                end else begin
                    acc_q <= acc_q + a_q;
                end
            end
            a_q <= a_q << 1;
            b_q <= b_q >> 1;
        end
    end

    assign result_o    = (op_q == MUL_LO) ? acc_q[XLEN-1:0] : acc_q[2*XLEN-1:XLEN];
    assign reg_waddr_o = waddr_q;
    assign busy_o      = busy_q;
    assign ready_o     = ready_q;

endmodule

// ==== src/exu_div.sv ====
/*
 * iterative restoring divider with RISC-V divide-by-zero and overflow results
 * ready pulses XLEN+2 cycles after start, special cases take the same time
 * start is ignored while busy
 */

`timescale 1ns/1ps

module exu_div import muldiv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  div_op_e               op_i,
    input  logic [XLEN-1:0]       dividend_i,
    input  logic [XLEN-1:0]       divisor_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    output logic                  busy_o,
    output logic                  ready_o,
    output logic [XLEN-1:0]       result_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o
);

    localparam int CNT_W = $clog2(XLEN);
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic                  is_signed;
    logic [XLEN:0]         rem_shift;
    logic                  step_ge;
    logic [XLEN-1:0]       quo_fix;
    logic [XLEN-1:0]       rem_fix;

    logic [XLEN-1:0]       dvd_q;
    logic [XLEN-1:0]       dvs_q;
    logic [XLEN-1:0]       quo_q;
    logic [XLEN-1:0]       rem_q;
    logic                  neg_a_q;
    logic                  neg_b_q;
    logic                  zero_q;
    logic                  ovf_q;
    div_op_e               op_q;
    logic [REG_ADDR_W-1:0] waddr_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  setup_q;
    logic                  busy_q;
    logic                  ready_q;

    assign is_signed = (op_i == DIV_S) || (op_i == REM_S);

    // one restoring step, the shifted remainder needs one extra bit
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign step_ge   = rem_shift >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            setup_q <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q  <= 1'b1;
                setup_q <= 1'b1;
            end else if (busy_q && setup_q) begin
                setup_q <= 1'b0;
                cnt_q   <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(XLEN-1)) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            dvd_q   <= dividend_i;
            dvs_q   <= divisor_i;
            neg_a_q <= is_signed && dividend_i[XLEN-1];
            neg_b_q <= is_signed && divisor_i[XLEN-1];
            zero_q  <= (divisor_i == '0);
            ovf_q   <= is_signed && (dividend_i == MOST_NEG) && (divisor_i == '1);
            op_q    <= op_i;
            waddr_q <= reg_waddr_i;
        end else if (busy_q && setup_q) begin
            // magnitudes, most negative maps onto itself as unsigned
            quo_q <= neg_a_q ? -dvd_q : dvd_q;
            dvs_q <= neg_b_q ? -dvs_q : dvs_q;
            rem_q <= '0;
        end else if (busy_q) begin
            if (step_ge) begin
                rem_q <= XLEN'(rem_shift - {1'b0, dvs_q});
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
            end
            quo_q <= {quo_q[XLEN-2:0], step_ge};
        end
    end

    // sign correction in the ready cycle
    assign quo_fix = (neg_a_q ^ neg_b_q) ? -quo_q : quo_q;
    assign rem_fix = neg_a_q ? -rem_q : rem_q;

    always_comb begin
        if (op_q == DIV_S || op_q == DIV_U) begin
            if (zero_q) begin
                result_o = '1;
            end else if (ovf_q) begin
                result_o = dvd_q;
            end else begin
                result_o = quo_fix;
            end
        end else begin
            if (zero_q) begin
                result_o = dvd_q;
            end else if (ovf_q) begin
                result_o = '0;
            end else begin
                result_o = rem_fix;
            end
        end
    end

    assign reg_waddr_o = waddr_q;
    assign busy_o      = busy_q;
    assign ready_o     = ready_q;

endmodule

// ==== src/exu_muldiv.sv ====
/*
 * M-extension execution subsystem top level
 * XLEN is passed down to the control block and both units
 */

`timescale 1ns/1ps

module exu_muldiv import muldiv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_muldiv_i,
    input  muldiv_op_e            muldiv_op_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    input  logic [XLEN-1:0]       reg1_rdata_i,
    input  logic [XLEN-1:0]       reg2_rdata_i,
    output logic                  muldiv_hold_flag_o,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o,
    output logic [XLEN-1:0]       reg_wdata_o
);

    // control to multiplier
    logic                  mul_start;
    mul_op_e               mul_op;
    logic [XLEN-1:0]       mul_multiplicand;
    logic [XLEN-1:0]       mul_multiplier;
    logic [REG_ADDR_W-1:0] mul_waddr_in;

    // multiplier to control
    logic                  mul_busy;
    logic                  mul_ready;
    logic [XLEN-1:0]       mul_result;
    logic [REG_ADDR_W-1:0] mul_waddr_out;

    // control to divider
    logic                  div_start;
    div_op_e               div_op;
    logic [XLEN-1:0]       div_dividend;
    logic [XLEN-1:0]       div_divisor;
    logic [REG_ADDR_W-1:0] div_waddr_in;

    // divider to control
    logic                  div_busy;
    logic                  div_ready;
    logic [XLEN-1:0]       div_result;
    logic [REG_ADDR_W-1:0] div_waddr_out;

    exu_muldiv_ctrl #(
        .XLEN (XLEN)
    ) exu_muldiv_ctrl_inst (
        .clk                (clk),
        .reset_i            (reset_i),
        .req_muldiv_i       (req_muldiv_i),
        .muldiv_op_i        (muldiv_op_i),
        .reg_waddr_i        (reg_waddr_i),
        .reg1_rdata_i       (reg1_rdata_i),
        .reg2_rdata_i       (reg2_rdata_i),
        .mul_ready_i        (mul_ready),
        .mul_busy_i         (mul_busy),
        .mul_result_i       (mul_result),
        .mul_reg_waddr_i    (mul_waddr_out),
        .div_ready_i        (div_ready),
        .div_busy_i         (div_busy),
        .div_result_i       (div_result),
        .div_reg_waddr_i    (div_waddr_out),
        .mul_start_o        (mul_start),
        .mul_op_o           (mul_op),
        .mul_multiplicand_o (mul_multiplicand),
        .mul_multiplier_o   (mul_multiplier),
        .mul_reg_waddr_o    (mul_waddr_in),
        .div_start_o        (div_start),
        .div_op_o           (div_op),
        .div_dividend_o     (div_dividend),
        .div_divisor_o      (div_divisor),
        .div_reg_waddr_o    (div_waddr_in),
        .muldiv_hold_flag_o (muldiv_hold_flag_o),
        .reg_we_o           (reg_we_o),
        .reg_waddr_o        (reg_waddr_o),
        .reg_wdata_o        (reg_wdata_o)
    );

    exu_mul #(
        .XLEN (XLEN)
    ) exu_mul_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .start_i        (mul_start),
        .op_i           (mul_op),
        .multiplicand_i (mul_multiplicand),
        .multiplier_i   (mul_multiplier),
        .reg_waddr_i    (mul_waddr_in),
        .busy_o         (mul_busy),
        .ready_o        (mul_ready),
        .result_o       (mul_result),
        .reg_waddr_o    (mul_waddr_out)
    );

    exu_div #(
        .XLEN (XLEN)
    ) exu_div_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .op_i        (div_op),
        .dividend_i  (div_dividend),
        .divisor_i   (div_divisor),
        .reg_waddr_i (div_waddr_in),
        .busy_o      (div_busy),
        .ready_o     (div_ready),
        .result_o    (div_result),
        .reg_waddr_o (div_waddr_out)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
/*
 * free-running testbench clock, starts low
 */

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== tests/tb_exu_muldiv.sv ====
/*
 * table-driven testbench for the M-extension subsystem at XLEN 32
 * fixed entries carry hand-derived results and random entries use the model
 * inputs change on the rising edge and outputs are sampled on the falling edge
 */

`timescale 1ns/1ps

module tb_exu_muldiv import muldiv_pkg::*;;

    localparam int XLEN       = 32;
    localparam int NUM_RANDOM = 24;
    localparam int WAIT_LIMIT = 100;

    logic                  clk;
    logic                  reset;
    logic                  req_muldiv;
    muldiv_op_e            muldiv_op;
    logic [REG_ADDR_W-1:0] reg_waddr;
    logic [XLEN-1:0]       reg1_rdata;
    logic [XLEN-1:0]       reg2_rdata;
    logic                  hold_flag;
    logic                  reg_we;
    logic [REG_ADDR_W-1:0] wb_waddr;
    logic [XLEN-1:0]       wb_wdata;

    // stimulus table
    muldiv_op_e            op_tbl[$];
    logic [XLEN-1:0]       a_tbl[$];
    logic [XLEN-1:0]       b_tbl[$];
    logic [XLEN-1:0]       exp_tbl[$];
    logic [REG_ADDR_W-1:0] waddr_tbl[$];
    bit                    gap_tbl[$];

    integer seed = 32'h817e_df01;

    tb_clk_gen #(.PERIOD_NS(20.0)) clk_gen_inst (.clk_o(clk));

    exu_muldiv #(
        .XLEN (XLEN)
    ) exu_muldiv_inst (
        .clk                (clk),
        .reset_i            (reset),
        .req_muldiv_i       (req_muldiv),
        .muldiv_op_i        (muldiv_op),
        .reg_waddr_i        (reg_waddr),
        .reg1_rdata_i       (reg1_rdata),
        .reg2_rdata_i       (reg2_rdata),
        .muldiv_hold_flag_o (hold_flag),
        .reg_we_o           (reg_we),
        .reg_waddr_o        (wb_waddr),
        .reg_wdata_o        (wb_wdata)
    );

    // behavioral reference in 64-bit arithmetic with the RISC-V special cases
    function automatic logic [31:0] model_result(input muldiv_op_e op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [63:0] a_sx;
        logic [63:0] a_zx;
        logic [63:0] b_sx;
        logic [63:0] b_zx;
        logic [63:0] prod;
        longint      sa;
        longint      sb;
        logic        ovf;
        a_sx = {{32{a[31]}}, a};
        a_zx = {32'b0, a};
        b_sx = {{32{b[31]}}, b};
        b_zx = {32'b0, b};
        sa   = $signed(a);
        sb   = $signed(b);
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_MUL:    prod = a_zx * b_zx;
            OP_MULH:   prod = a_sx * b_sx;
            OP_MULHSU: prod = a_sx * b_zx;
            default:   prod = a_zx * b_zx;
        endcase
        case (op)
            OP_MUL:    return prod[31:0];
            OP_MULH, OP_MULHSU, OP_MULHU: return prod[63:32];
            OP_DIV:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'(sa / sb));
            OP_DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
            OP_REM:    return (b == 0) ? a : (ovf ? 32'h0 : 32'(sa % sb));
            default:   return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic add_entry(input muldiv_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] expected,
                             input bit gap);
        waddr_tbl.push_back(REG_ADDR_W'(op_tbl.size() % 31 + 1));
        op_tbl.push_back(op);
        a_tbl.push_back(a);
        b_tbl.push_back(b);
        exp_tbl.push_back(expected);
        gap_tbl.push_back(gap);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        muldiv_op_e  op;
        // multiply variants
        add_entry(OP_MUL,    32'h0000_0003, 32'hffff_fffe, 32'hffff_fffa, 1'b1);
        add_entry(OP_MUL,    32'h1234_5678, 32'h0000_0000, 32'h0000_0000, 1'b1);
        add_entry(OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 1'b1);
        add_entry(OP_MUL,    32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000, 1'b1);
        add_entry(OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        add_entry(OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b1);
        add_entry(OP_MULH,   32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff, 1'b1);
        add_entry(OP_MULH,   32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000, 1'b1);
        add_entry(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        add_entry(OP_MULHSU, 32'h8000_0000, 32'h0000_0002, 32'hffff_ffff, 1'b1);
        add_entry(OP_MULHSU, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001, 1'b1);
        add_entry(OP_MULHSU, 32'hffff_fffe, 32'h0000_0003, 32'hffff_ffff, 1'b1);
        add_entry(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1'b1);
        add_entry(OP_MULHU,  32'h8000_0000, 32'h0000_0002, 32'h0000_0001, 1'b1);
        // divide and remainder
        add_entry(OP_DIV,    32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, 1'b1);
        add_entry(OP_REM,    32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 1'b1);
        add_entry(OP_DIV,    32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd, 1'b1);
        add_entry(OP_REM,    32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, 1'b1);
        add_entry(OP_DIV,    32'h8000_0000, 32'h0000_0002, 32'hc000_0000, 1'b1);
        add_entry(OP_REM,    32'h8000_0000, 32'h0000_0003, 32'hffff_fffe, 1'b1);
        add_entry(OP_DIV,    32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 1'b1);
        add_entry(OP_DIVU,   32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 1'b1);
        add_entry(OP_REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1'b1);
        add_entry(OP_DIVU,   32'hffff_ffff, 32'h0000_000a, 32'h1999_9999, 1'b1);
        add_entry(OP_REMU,   32'hffff_ffff, 32'h0000_000a, 32'h0000_0005, 1'b1);
        add_entry(OP_DIVU,   32'h0000_0005, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        add_entry(OP_REMU,   32'h0000_0005, 32'hffff_ffff, 32'h0000_0005, 1'b1);
        // divide by zero and signed overflow
        add_entry(OP_DIV,    32'h0000_0007, 32'h0000_0000, 32'hffff_ffff, 1'b1);
        add_entry(OP_DIVU,   32'h0000_0007, 32'h0000_0000, 32'hffff_ffff, 1'b1);
        add_entry(OP_REM,    32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9, 1'b1);
        add_entry(OP_REMU,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 1'b1);
        add_entry(OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b1);
        add_entry(OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        add_entry(OP_DIVU,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        add_entry(OP_REMU,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b1);
        // random run where multiply and divide alternate back to back
        for (int k = 0; k < NUM_RANDOM; k++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            if (r[5:3] == 3'd0) begin
                b = '0;
            end else if (r[5:3] == 3'd1) begin
                b = 32'(r[15:8]);
            end
            op = muldiv_op_e'({k[0], r[1:0]});
            add_entry(op, a, b, model_result(op, a, b), 1'b0);
        end
    endtask

    task automatic apply_entry(input int idx);
        @(posedge clk);
        req_muldiv <= 1'b1;
        muldiv_op  <= op_tbl[idx];
        reg_waddr  <= waddr_tbl[idx];
        reg1_rdata <= a_tbl[idx];
        reg2_rdata <= b_tbl[idx];
    endtask

    // hold must stay high until the single write-back cycle
    task automatic wait_for_write(input int idx);
        int         cycles;
        string      name;
        muldiv_op_e op;
        cycles = 0;
        op     = op_tbl[idx];
        name   = $sformatf("entry %0d op %s", idx, op.name());
        @(negedge clk);
        while (!reg_we) begin
            check_value({name, " hold"}, 32'd1, {31'b0, hold_flag});
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: no register write for entry %0d after %0d cycles",
                         idx, cycles);
                $display("*** TEST FAILED ***");
                $fatal(1, "write-back timeout");
            end
            @(negedge clk);
        end
        check_value({name, " hold in write-back"}, 32'd0, {31'b0, hold_flag});
        check_value({name, " waddr"}, {27'b0, waddr_tbl[idx]}, {27'b0, wb_waddr});
        check_value({name, " wdata"}, exp_tbl[idx], wb_wdata);
    endtask

    task automatic idle_check(input int cycles, input string label);
        @(posedge clk);
        req_muldiv <= 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            check_value({label, " reg_we"}, 32'd0, {31'b0, reg_we});
            check_value({label, " hold"}, 32'd0, {31'b0, hold_flag});
        end
    endtask

    initial begin
        reset      = 1'b1;
        req_muldiv = 1'b0;
        muldiv_op  = OP_MUL;
        reg_waddr  = '0;
        reg1_rdata = '0;
        reg2_rdata = '0;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle_check(5, "after reset");
        for (int i = 0; i < op_tbl.size(); i++) begin
            apply_entry(i);
            wait_for_write(i);
            if (gap_tbl[i]) begin
                idle_check(3, $sformatf("gap after entry %0d", i));
            end
        end
        idle_check(5, "after last request");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== exu_muldiv.f ====
src/muldiv_pkg.sv
src/exu_muldiv_ctrl.sv
src/exu_mul.sv
src/exu_div.sv
src/exu_muldiv.sv
tests/tb_clk_gen.sv
tests/tb_exu_muldiv.sv

// ==== Bender.yml ====
package:
  name: exu_muldiv

sources:
  - src/muldiv_pkg.sv
  - src/exu_muldiv_ctrl.sv
  - src/exu_mul.sv
  - src/exu_div.sv
  - src/exu_muldiv.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_exu_muldiv.sv
